// ==== common/oq_pkg.sv ====
package oq_pkg;

    ////////////////////////////////////////////////////////////
    // bus and metadata widths
    ////////////////////////////////////////////////////////////

    localparam int data_w = 32;
    // one keep bit per data byte
    localparam int keep_w = data_w / 8;
    localparam int user_w = 8;
    localparam int rank_w = 8;

    ////////////////////////////////////////////////////////////
    // buffer and calendar sizing
    ////////////////////////////////////////////////////////////

    localparam int addr_w = 6;
    localparam int buf_depth = 64;
    // used words at or above this raise almost-full
    localparam int buf_full_on = 48;
    localparam int pifo_depth = 8;
    // holds 0 .. pifo_depth
    localparam int pifo_cnt_w = 4;

    typedef logic [addr_w-1:0] buf_addr_t;
    // one extra bit so a full buffer still counts
    typedef logic [addr_w:0] buf_cnt_t;
    typedef logic [rank_w-1:0] rank_t;

    // one bus word as stored in the buffer
    typedef struct packed {
        logic [data_w-1:0] data;
        logic [keep_w-1:0] keep;
        logic [user_w-1:0] user;
        logic              last;
    } pkt_word_t;

    // calendar entry, sorted on rank
    typedef struct packed {
        rank_t     rank;
        buf_addr_t sop_addr;
    } pkt_desc_t;

    // dequeue FSM
    typedef enum logic [1:0] {
        deq_idle  = 2'd0,
        deq_fetch = 2'd1,
        deq_send  = 2'd2
    } deq_state_e;

endpackage

// ==== compile.f ====
+incdir+verification
common/oq_pkg.sv
pkt_buffer/buffer_addr_manager.sv
pkt_buffer/pkt_buffer.sv
verilog/pkt_enqueue.sv
verilog/pifo_calendar.sv
verilog/pkt_dequeue.sv
verilog/output_queue.sv
verification/output_queue_tb.sv

// ==== pkt_buffer/buffer_addr_manager.sv ====
`timescale 1ns/1ns

module buffer_addr_manager
(
    input  logic              axis_aclk,
    input  logic              axis_resetn,
    input  logic              wr_en,
    input  logic              free_en,
    input  oq_pkg::buf_addr_t free_addr,
    input  oq_pkg::buf_addr_t link_addr,
    output oq_pkg::buf_addr_t fl_head,
    output oq_pkg::buf_addr_t rd_link,
    output oq_pkg::buf_cnt_t  buf_count,
    output logic              buf_almost_full
);
    import oq_pkg::*;

    // next-address table, shared by free and used chains
    buf_addr_t link_tbl [buf_depth];
    buf_addr_t fl_tail;
    buf_cnt_t  cnt_nxt;

    ////////////////////////////////////////////////////////////
    // free list and link table
    ////////////////////////////////////////////////////////////

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            // chain every word in address order
            for (int i = 0; i < buf_depth; i++)
                link_tbl[i] <= buf_addr_t'(i + 1);
            fl_head <= '0;
            fl_tail <= buf_addr_t'(buf_depth - 1);
        end
        else
        begin
            // allocate: head moves along its own link
            if (wr_en)
                fl_head <= link_tbl[fl_head];
            // release: hang the address behind the tail
            if (free_en)
            begin
                link_tbl[fl_tail] <= free_addr;
                fl_tail <= free_addr;
            end
        end
    end

    // link of the word being read, valid with its data
    always_ff @(posedge axis_aclk)
    begin
        if (free_en)
            rd_link <= link_tbl[link_addr];
    end

    ////////////////////////////////////////////////////////////
    // occupancy
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        cnt_nxt = buf_count;
        if (wr_en && !free_en)
            cnt_nxt = buf_count + 1'b1;
        else if (free_en && !wr_en)
            cnt_nxt = buf_count - 1'b1;
    end

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            buf_count       <= '0;
            buf_almost_full <= 1'b0;
        end
        else
        begin
            buf_count       <= cnt_nxt;
            buf_almost_full <= (cnt_nxt >= buf_full_on);
        end
    end

    // keep two free words so the head link is always valid
    a_no_write_near_full : assert property (
        @(posedge axis_aclk) disable iff (!axis_resetn)
        wr_en |-> buf_count < buf_cnt_t'(buf_depth - 1)
    );

    a_no_free_when_empty : assert property (
        @(posedge axis_aclk) disable iff (!axis_resetn)
        free_en |-> buf_count != '0
    );

endmodule

// ==== pkt_buffer/pkt_buffer.sv ====
`timescale 1ns/1ns

module pkt_buffer
(
    input  logic              axis_aclk,
    input  logic              axis_resetn,
    input  logic              wr_en,
    input  oq_pkg::pkt_word_t wr_word,
    input  logic              rd_en,
    input  oq_pkg::buf_addr_t rd_addr,
    output oq_pkg::buf_addr_t fl_head,
    output oq_pkg::pkt_word_t rd_word,
    output oq_pkg::buf_addr_t rd_link,
    output oq_pkg::buf_cnt_t  buf_count,
    output logic              buf_almost_full
);
    import oq_pkg::*;

    // word storage
    pkt_word_t mem [buf_depth];

    ////////////////////////////////////////////////////////////
    // word memory with one cycle read
    ////////////////////////////////////////////////////////////

    always_ff @(posedge axis_aclk)
    begin
        // writes always go to the free-list head
        if (wr_en)
            mem[fl_head] <= wr_word;
        // registered read port
        if (rd_en)
            rd_word <= mem[rd_addr];
    end

    ////////////////////////////////////////////////////////////
    // address bookkeeping
    ////////////////////////////////////////////////////////////

    // a read returns its word to the free list
    // and looks up the word that follows it
    buffer_addr_manager u_addr_mgr
    (
        .axis_aclk       (axis_aclk),
        .axis_resetn     (axis_resetn),
        .wr_en           (wr_en),
        .free_en         (rd_en),
        .free_addr       (rd_addr),
        .link_addr       (rd_addr),
        .fl_head         (fl_head),
        .rd_link         (rd_link),
        .buf_count       (buf_count),
        .buf_almost_full (buf_almost_full)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the output queue testbench with Verilator

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module output_queue_tb -o output_queue_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/output_queue_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the verdict comes from the log
if grep -q "Everything OK" "$log"; then
    exit 0
fi
echo "pass line not found in $log"
exit 1

// ==== verification/oq_checks.svh ====
`ifndef OQ_CHECKS_SVH
`define OQ_CHECKS_SVH

////////////////////////////////////////////////////////////
// error tallies per kind of check
////////////////////////////////////////////////////////////

int word_errs = 0;
int count_errs = 0;
int flag_errs = 0;
// timeouts and out of place packets
int other_errs = 0;

// cycles any single wait may take
localparam int wait_limit = 2000;

////////////////////////////////////////////////////////////
// typed compares
////////////////////////////////////////////////////////////

task automatic check_word(input string name, input pkt_word_t got, input pkt_word_t exp);
    if (got !== exp)
    begin
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        word_errs++;
    end
endtask

task automatic check_count(input string name, input buf_cnt_t got, input buf_cnt_t exp);
    if (got !== exp)
    begin
        $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        count_errs++;
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
        $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        flag_errs++;
    end
endtask

////////////////////////////////////////////////////////////
// bounded waits
////////////////////////////////////////////////////////////

// until n_pkts whole packets have left the DUT
task automatic wait_drained(input int n_pkts);
    int cycles;
    cycles = 0;
    while (rcv_pkts < n_pkts && cycles < wait_limit)
    begin
        @(posedge axis_aclk);
        cycles++;
    end
    if (rcv_pkts < n_pkts)
    begin
        $display("timeout at %0t: only %0d of %0d packets came out", $time, rcv_pkts, n_pkts);
        other_errs++;
    end
endtask

// until the buffer holds exactly exp words
task automatic wait_count(input buf_cnt_t exp);
    int cycles;
    cycles = 0;
    while (buf_count !== exp && cycles < wait_limit)
    begin
        @(negedge axis_aclk);
        cycles++;
    end
    if (buf_count !== exp)
    begin
        $display("timeout at %0t: buffer word count stuck at %0d", $time, buf_count);
        other_errs++;
    end
endtask

`endif

// ==== verification/output_queue_tb.sv ====
`timescale 1ns/1ns

module output_queue_tb;
    import oq_pkg::*;

    localparam int n_pkts = 26;
    localparam int n_batches = 5;
    localparam int max_len = 8;

    // one row per packet, batches run one after the other
    typedef struct packed {
        logic [2:0]  batch;
        rank_t       rank;
        logic [3:0]  len;
        logic [15:0] base;
    } pkt_row_t;

    logic      axis_aclk;
    logic      axis_resetn;
    logic      in_valid;
    pkt_word_t in_word;
    rank_t     in_rank;
    logic      out_ready;
    logic      out_valid;
    pkt_word_t out_word;
    logic      buf_almost_full;
    logic      pifo_full;
    buf_cnt_t  buf_count;

    pkt_row_t  pkt_tbl [n_pkts];
    // ready per batch: 0 always, 1 held low until release, 2 random
    int        batch_mode [n_batches];
    pkt_word_t exp_word [n_pkts][max_len];
    logic      got_pkt [n_pkts];
    // expected leaving order, lowest rank first
    int        order_q [$];
    int        cur_batch;
    int        cur_pkt;
    int        cur_idx;
    int        rcv_pkts;
    logic      released;

    `include "oq_checks.svh"

    output_queue DUT
    (
        .axis_aclk       (axis_aclk),
        .axis_resetn     (axis_resetn),
        .in_valid        (in_valid),
        .in_word         (in_word),
        .in_rank         (in_rank),
        .out_ready       (out_ready),
        .out_valid       (out_valid),
        .out_word        (out_word),
        .buf_almost_full (buf_almost_full),
        .pifo_full       (pifo_full),
        .buf_count       (buf_count)
    );

    always #50 axis_aclk = ~axis_aclk;

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    // random payload, user carries the packet index
    task automatic send_pkt(input int p);
        pkt_word_t w;
        for (int i = 0; i < int'(pkt_tbl[p].len); i++)
        begin
            w.data = {pkt_tbl[p].base, 16'($urandom)};
            w.last = (i == int'(pkt_tbl[p].len) - 1);
            w.keep = w.last ? keep_w'($urandom) : '1;
            w.user = user_w'(p);
            exp_word[p][i] = w;
            @(negedge axis_aclk);
            in_valid = 1'b1;
            in_word = w;
            in_rank = pkt_tbl[p].rank;
        end
    endtask

    // sorted insert, behind equal or lower ranks
    task automatic model_insert(input int p);
        int pos;
        pos = 0;
        while (pos < order_q.size() && pkt_tbl[order_q[pos]].rank <= pkt_tbl[p].rank)
            pos++;
        order_q.insert(pos, p);
    endtask

    task automatic run_batch(input int b);
        int n_in;
        int n_words;
        n_in = 0;
        n_words = 0;
        @(posedge axis_aclk);
        cur_batch = b;
        released = 1'b0;
        rcv_pkts = 0;
        order_q.delete();
        for (int p = 0; p < n_pkts; p++)
        begin
            if (int'(pkt_tbl[p].batch) == b)
            begin
                model_insert(p);
                send_pkt(p);
                n_in++;
                n_words += int'(pkt_tbl[p].len);
            end
        end
        @(negedge axis_aclk);
        in_valid = 1'b0;
        // input stage plus count update
        repeat (2) @(negedge axis_aclk);
        if (batch_mode[b] == 1)
        begin
            check_count("buf_count", buf_count, buf_cnt_t'(n_words));
            check_flag("buf_almost_full", buf_almost_full, n_words >= buf_full_on);
            check_flag("pifo_full", pifo_full, n_in == pifo_depth);
            @(posedge axis_aclk);
            released = 1'b1;
        end
        wait_drained(n_in);
        wait_count(buf_cnt_t'(0));
        repeat (2) @(negedge axis_aclk);
        check_count("buf_count", buf_count, buf_cnt_t'(0));
        check_flag("buf_almost_full", buf_almost_full, 1'b0);
        check_flag("pifo_full", pifo_full, 1'b0);
        check_flag("out_valid", out_valid, 1'b0);
    endtask

    ////////////////////////////////////////////////////////////
    // ready driver and scoreboard
    ////////////////////////////////////////////////////////////

    task automatic record_word();
        int   id;
        logic ok;
        ok = 1'b1;
        if (cur_pkt < 0)
        begin
            // first word picks the packet it should belong to
            if (batch_mode[cur_batch] == 2)
                id = int'(out_word.user);
            else if (order_q.size() > 0)
                id = order_q.pop_front();
            else
                id = -1;
            if (id < 0 || id >= n_pkts || int'(pkt_tbl[id].batch) != cur_batch || got_pkt[id])
            begin
                $display("unexpected packet at %0t with user field %0d", $time, out_word.user);
                other_errs++;
                ok = 1'b0;
            end
            else
            begin
                cur_pkt = id;
                cur_idx = 0;
            end
        end
        if (ok)
        begin
            check_word("out_word", out_word, exp_word[cur_pkt][cur_idx]);
            cur_idx++;
            if (out_word.last || cur_idx >= int'(pkt_tbl[cur_pkt].len))
            begin
                got_pkt[cur_pkt] = 1'b1;
                rcv_pkts++;
                cur_pkt = -1;
            end
        end
    endtask

    // a word taken here transfers on the next rising edge
    always @(negedge axis_aclk)
    begin
        logic rdy;
        if (batch_mode[cur_batch] == 2)
            rdy = ($urandom % 2) == 1;
        else
            rdy = (batch_mode[cur_batch] == 0) || released;
        out_ready = rdy;
        if (axis_resetn && out_valid && rdy)
            record_word();
    end

    initial
    begin
        axis_aclk = 1'b0;
        axis_resetn = 1'b0;
        in_valid = 1'b0;
        in_word = '0;
        in_rank = '0;
        out_ready = 1'b0;
        released = 1'b0;
        cur_batch = 0;
        cur_pkt = -1;
        cur_idx = 0;
        rcv_pkts = 0;
        void'($urandom(38));
        // single packet, held batch, random ready batch, 48 words, 8 short ones
        pkt_tbl = '{
            '{3'd0, 8'd5, 4'd4, 16'h10},
            '{3'd1, 8'd7, 4'd3, 16'h20}, '{3'd1, 8'd3, 4'd2, 16'h21}, '{3'd1, 8'd7, 4'd5, 16'h22},
            '{3'd1, 8'd1, 4'd1, 16'h23}, '{3'd1, 8'd3, 4'd4, 16'h24}, '{3'd1, 8'd7, 4'd2, 16'h25},
            '{3'd2, 8'd2, 4'd6, 16'h30}, '{3'd2, 8'd9, 4'd3, 16'h31}, '{3'd2, 8'd2, 4'd1, 16'h32},
            '{3'd2, 8'd4, 4'd7, 16'h33}, '{3'd2, 8'd0, 4'd4, 16'h34},
            '{3'd3, 8'd40, 4'd8, 16'h40}, '{3'd3, 8'd30, 4'd8, 16'h41}, '{3'd3, 8'd40, 4'd8, 16'h42},
            '{3'd3, 8'd20, 4'd8, 16'h43}, '{3'd3, 8'd30, 4'd8, 16'h44}, '{3'd3, 8'd10, 4'd8, 16'h45},
            '{3'd4, 8'd6, 4'd1, 16'h50}, '{3'd4, 8'd2, 4'd1, 16'h51}, '{3'd4, 8'd6, 4'd1, 16'h52},
            '{3'd4, 8'd2, 4'd1, 16'h53}, '{3'd4, 8'd9, 4'd1, 16'h54}, '{3'd4, 8'd0, 4'd1, 16'h55},
            '{3'd4, 8'd6, 4'd1, 16'h56}, '{3'd4, 8'd2, 4'd1, 16'h57}
        };
        batch_mode = '{0, 1, 2, 1, 1};
        for (int p = 0; p < n_pkts; p++)
            got_pkt[p] = 1'b0;
        repeat (2) @(negedge axis_aclk);
        axis_resetn = 1'b1;
        @(negedge axis_aclk);
        // idle state out of reset
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("buf_almost_full", buf_almost_full, 1'b0);
        check_flag("pifo_full", pifo_full, 1'b0);
        check_count("buf_count", buf_count, buf_cnt_t'(0));
        for (int b = 0; b < n_batches; b++)
            run_batch(b);
        $display("errors: word %0d, count %0d, flag %0d, other %0d",
                 word_errs, count_errs, flag_errs, other_errs);
        if (word_errs + count_errs + flag_errs + other_errs == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// ==== verilog/output_queue.sv ====
`timescale 1ns/1ns

module output_queue
(
    input  logic              axis_aclk,
    input  logic              axis_resetn,
    input  logic              in_valid,
    input  oq_pkg::pkt_word_t in_word,
    input  oq_pkg::rank_t     in_rank,
    input  logic              out_ready,
    output logic              out_valid,
    output oq_pkg::pkt_word_t out_word,
    output logic              buf_almost_full,
    output logic              pifo_full,
    output oq_pkg::buf_cnt_t  buf_count
);
    import oq_pkg::*;

    ////////////////////////////////////////////////////////////
    // internal nets
    ////////////////////////////////////////////////////////////

    // enqueue to buffer
    logic      wr_en;
    pkt_word_t wr_word;
    buf_addr_t fl_head;
    // enqueue to calendar
    logic      ins_en;
    pkt_desc_t ins_desc;
    // calendar to dequeue
    logic      pop_en;
    pkt_desc_t pifo_top;
    logic      pifo_empty;
    // dequeue to buffer and back
    logic      rd_en;
    buf_addr_t rd_addr;
    pkt_word_t rd_word;
    buf_addr_t rd_link;

    // producer
    pkt_enqueue u_enqueue
    (
        .axis_aclk       (axis_aclk),
        .axis_resetn     (axis_resetn),
        .in_valid        (in_valid),
        .in_word         (in_word),
        .in_rank         (in_rank),
        .fl_head         (fl_head),
        .buf_almost_full (buf_almost_full),
        .wr_en           (wr_en),
        .wr_word         (wr_word),
        .ins_en          (ins_en),
        .ins_desc        (ins_desc)
    );

    // linked-list word store
    pkt_buffer u_buffer
    (
        .axis_aclk       (axis_aclk),
        .axis_resetn     (axis_resetn),
        .wr_en           (wr_en),
        .wr_word         (wr_word),
        .rd_en           (rd_en),
        .rd_addr         (rd_addr),
        .fl_head         (fl_head),
        .rd_word         (rd_word),
        .rd_link         (rd_link),
        .buf_count       (buf_count),
        .buf_almost_full (buf_almost_full)
    );

    // rank-ordered descriptors
    pifo_calendar u_calendar
    (
        .axis_aclk   (axis_aclk),
        .axis_resetn (axis_resetn),
        .ins_en      (ins_en),
        .ins_desc    (ins_desc),
        .pop_en      (pop_en),
        .pifo_top    (pifo_top),
        .pifo_empty  (pifo_empty),
        .pifo_full   (pifo_full)
    );

    // consumer
    pkt_dequeue u_dequeue
    (
        .axis_aclk   (axis_aclk),
        .axis_resetn (axis_resetn),
        .pifo_top    (pifo_top),
        .pifo_empty  (pifo_empty),
        .pop_en      (pop_en),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_word     (rd_word),
        .rd_link     (rd_link),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .out_word    (out_word)
    );

endmodule

// ==== verilog/pifo_calendar.sv ====
`timescale 1ns/1ns

module pifo_calendar
(
    input  logic              axis_aclk,
    input  logic              axis_resetn,
    input  logic              ins_en,
    input  oq_pkg::pkt_desc_t ins_desc,
    input  logic              pop_en,
    output oq_pkg::pkt_desc_t pifo_top,
    output logic              pifo_empty,
    output logic              pifo_full
);
    import oq_pkg::*;

    // sorted entries, index 0 is the lowest rank
    pkt_desc_t entry     [pifo_depth];
    pkt_desc_t shifted   [pifo_depth];
    pkt_desc_t entry_nxt [pifo_depth];
    logic [pifo_cnt_w-1:0] cnt;
    logic [pifo_cnt_w-1:0] cnt_pop;
    logic [pifo_cnt_w-1:0] ins_pos;

    ////////////////////////////////////////////////////////////
    // pop first, then insert into the result
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        cnt_pop = cnt - pifo_cnt_w'(pop_en);
        // pop shifts everything one slot down
        for (int i = 0; i < pifo_depth - 1; i++)
            shifted[i] = pop_en ? entry[i + 1] : entry[i];
        shifted[pifo_depth - 1] = entry[pifo_depth - 1];

        // behind every entry of equal or lower rank
        ins_pos = '0;
        for (int i = 0; i < pifo_depth; i++)
        begin
            if (i < cnt_pop && shifted[i].rank <= ins_desc.rank)
                ins_pos = ins_pos + 1'b1;
        end

        // open a gap at ins_pos
        entry_nxt[0] = (ins_en && ins_pos == '0) ? ins_desc : shifted[0];
        for (int i = 1; i < pifo_depth; i++)
        begin
            if (!ins_en || i < ins_pos)
                entry_nxt[i] = shifted[i];
            else if (i == ins_pos)
                entry_nxt[i] = ins_desc;
            else
                entry_nxt[i] = shifted[i - 1];
        end
    end

    // slots past cnt are don't care
    always_ff @(posedge axis_aclk)
    begin
        entry <= entry_nxt;
    end

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
            cnt <= '0;
        else
            cnt <= cnt_pop + pifo_cnt_w'(ins_en);
    end

    // head and status
    assign pifo_top   = entry[0];
    assign pifo_empty = (cnt == '0);
    assign pifo_full  = (cnt == pifo_cnt_w'(pifo_depth));

    // a same cycle pop makes room
    a_no_insert_when_full : assert property (
        @(posedge axis_aclk) disable iff (!axis_resetn)
        ins_en |-> !pifo_full || pop_en
    );

    a_no_pop_when_empty : assert property (
        @(posedge axis_aclk) disable iff (!axis_resetn)
        pop_en |-> !pifo_empty
    );

endmodule

// ==== verilog/pkt_dequeue.sv ====
`timescale 1ns/1ns

module pkt_dequeue
(
    input  logic              axis_aclk,
    input  logic              axis_resetn,
    input  oq_pkg::pkt_desc_t pifo_top,
    input  logic              pifo_empty,
    output logic              pop_en,
    output logic              rd_en,
    output oq_pkg::buf_addr_t rd_addr,
    input  oq_pkg::pkt_word_t rd_word,
    input  oq_pkg::buf_addr_t rd_link,
    input  logic              out_ready,
    output logic              out_valid,
    output oq_pkg::pkt_word_t out_word
);
    import oq_pkg::*;

    deq_state_e state;
    deq_state_e state_nxt;
    // current word accepted downstream
    logic       xfer;

    assign xfer = out_valid && out_ready;

    ////////////////////////////////////////////////////////////
    // next state, pop and read strobes
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        state_nxt = state;
        pop_en    = 1'b0;
        rd_en     = 1'b0;
        // chain walk by default
        rd_addr   = rd_link;
        unique case (state)
            deq_idle:
            begin
                // take the lowest rank packet, read its first word
                if (out_ready && !pifo_empty)
                begin
                    pop_en    = 1'b1;
                    rd_en     = 1'b1;
                    rd_addr   = pifo_top.sop_addr;
                    state_nxt = deq_fetch;
                end
            end
            deq_fetch:
            begin
                // read data lands in the output register
                state_nxt = deq_send;
            end
            deq_send:
            begin
                if (xfer)
                begin
                    if (out_word.last)
                        state_nxt = deq_idle;
                    else
                    begin
                        // follow the link to the next word
                        rd_en     = 1'b1;
                        state_nxt = deq_fetch;
                    end
                end
            end
            default:
                state_nxt = deq_idle;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // state and registered output
    ////////////////////////////////////////////////////////////

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            state     <= deq_idle;
            out_valid <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            if (state == deq_fetch)
                out_valid <= 1'b1;
            else if (xfer)
                out_valid <= 1'b0;
        end
    end

    // output word only changes on a fresh buffer read
    always_ff @(posedge axis_aclk)
    begin
        if (state == deq_fetch)
            out_word <= rd_word;
    end

    // back-pressure holds the word in place
    a_out_stable : assert property (
        @(posedge axis_aclk) disable iff (!axis_resetn)
        out_valid && !out_ready |=> out_valid && $stable(out_word)
    );

endmodule

// ==== verilog/pkt_enqueue.sv ====
`timescale 1ns/1ns

module pkt_enqueue
(
    input  logic              axis_aclk,
    input  logic              axis_resetn,
    input  logic              in_valid,
    input  oq_pkg::pkt_word_t in_word,
    input  oq_pkg::rank_t     in_rank,
    input  oq_pkg::buf_addr_t fl_head,
    input  logic              buf_almost_full,
    output logic              wr_en,
    output oq_pkg::pkt_word_t wr_word,
    output logic              ins_en,
    output oq_pkg::pkt_desc_t ins_desc
);
    import oq_pkg::*;

    // input side packet boundary tracking
    logic      in_first;
    // delayed copy, marks the word now being written
    logic      sop_d1;
    rank_t     rank_d1;
    buf_addr_t sop_addr_q;

    ////////////////////////////////////////////////////////////
    // input register stage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            wr_en    <= 1'b0;
            in_first <= 1'b1;
            sop_d1   <= 1'b0;
        end
        else
        begin
            wr_en  <= in_valid;
            sop_d1 <= in_valid && in_first;
            // next word starts a packet only after a last
            if (in_valid)
                in_first <= in_word.last;
        end
    end

    // word and rank payload
    always_ff @(posedge axis_aclk)
    begin
        wr_word <= in_word;
        rank_d1 <= in_rank;
        // first word lands at the free-list head
        if (wr_en && sop_d1)
            sop_addr_q <= fl_head;
    end

    ////////////////////////////////////////////////////////////
    // descriptor on the last word
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        ins_en = wr_en && wr_word.last;
        ins_desc.rank = rank_d1;
        // single word packet, head is still the start
        ins_desc.sop_addr = sop_d1 ? fl_head : sop_addr_q;
    end

    // source has to hold off new packets near full
    a_no_sop_when_almost_full : assert property (
        @(posedge axis_aclk) disable iff (!axis_resetn)
        in_valid && in_first |-> !buf_almost_full
    );

endmodule
